//--- pe_ctrl_pkg.sv
/*
 * pe array controller shared definitions
 * register file address widths, config write kinds, the config word
 * layout and the step count type
 */
package pe_ctrl_pkg;

    // register file depth is 4 for every stream
    localparam int ACTV_AW = 2;
    localparam int WGT_AW  = 2;
    localparam int PSUM_AW = 2;
    localparam int CFG_W   = 16;

    typedef logic [15:0] step_t;

    // target of a configuration write
    typedef enum logic [2:0] {
        ACTV_LEN,
        WGT_LEN,
        PSUM_LEN,
        TOTAL,
        ENTRY
    } cfg_kind_t;

    // one config word, read as a count or as a table entry
    typedef union packed {
        step_t count;           // lengths and total step count
        struct packed {
            logic [CFG_W-ACTV_AW-WGT_AW-PSUM_AW-1:0] spare;
            logic [ACTV_AW-1:0] actv;
            logic [WGT_AW-1:0]  wgt;
            logic [PSUM_AW-1:0] psum;
        } entry;
    } cfg_word_t;

endpackage

//--- pe_ctrl_if.sv
/*
 * links between the controller pipeline stages
 * tm_index_if carries tile indices, rf_addr_if carries looked-up addresses
 */
`timescale 1ns/10ps

interface tm_index_if #(
    parameter int IDX_W = 4
);
    logic             valid;
    logic             ready;
    logic [IDX_W-1:0] actv_idx;
    logic [IDX_W-1:0] wgt_idx;
    logic [IDX_W-1:0] psum_idx;
    logic             actv_bank;
    logic             wgt_bank;
    logic             psum_bank;
    logic             actv_last;
    logic             wgt_last;
    logic             psum_last;

    modport source (output valid, actv_idx, wgt_idx, psum_idx, actv_bank, wgt_bank,
                    psum_bank, actv_last, wgt_last, psum_last, input ready);
    modport sink   (input valid, actv_idx, wgt_idx, psum_idx, actv_bank, wgt_bank,
                    psum_bank, actv_last, wgt_last, psum_last, output ready);
endinterface

interface rf_addr_if;
    import pe_ctrl_pkg::*;

    logic               valid;
    logic               ready;
    logic [ACTV_AW-1:0] actv_addr;
    logic [WGT_AW-1:0]  wgt_addr;
    logic [PSUM_AW-1:0] psum_addr;
    logic               actv_bank;
    logic               wgt_bank;
    logic               psum_bank;
    logic               actv_last;
    logic               wgt_last;
    logic               psum_last;

    modport source (output valid, actv_addr, wgt_addr, psum_addr, actv_bank, wgt_bank,
                    psum_bank, actv_last, wgt_last, psum_last, input ready);
    modport sink   (input valid, actv_addr, wgt_addr, psum_addr, actv_bank, wgt_bank,
                    psum_bank, actv_last, wgt_last, psum_last, output ready);
endinterface

//--- tm_config_store.sv
/*
 * temporal mapping configuration store
 * takes config writes while the controller is idle and holds the tile
 * lengths, the total step count and the rf address table
 */
`timescale 1ns/10ps

module tm_config_store #(
    parameter int TM_DEPTH = 16
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cfg_valid,
    input  pe_ctrl_pkg::cfg_kind_t            cfg_kind,
    input  logic [$clog2(TM_DEPTH)-1:0]       cfg_index,
    input  pe_ctrl_pkg::cfg_word_t            cfg_data,
    output logic                              cfg_ready,
    input  logic                              busy,
    output pe_ctrl_pkg::step_t                actv_len,
    output pe_ctrl_pkg::step_t                wgt_len,
    output pe_ctrl_pkg::step_t                psum_len,
    output pe_ctrl_pkg::step_t                total,
    input  logic [$clog2(TM_DEPTH)-1:0]       actv_idx,
    input  logic [$clog2(TM_DEPTH)-1:0]       wgt_idx,
    input  logic [$clog2(TM_DEPTH)-1:0]       psum_idx,
    output logic [pe_ctrl_pkg::ACTV_AW-1:0]   actv_addr,
    output logic [pe_ctrl_pkg::WGT_AW-1:0]    wgt_addr,
    output logic [pe_ctrl_pkg::PSUM_AW-1:0]   psum_addr
);
    import pe_ctrl_pkg::*;

    logic [ACTV_AW-1:0] actv_tab [TM_DEPTH];
    logic [WGT_AW-1:0]  wgt_tab  [TM_DEPTH];
    logic [PSUM_AW-1:0] psum_tab [TM_DEPTH];
    logic               wr;

    assign cfg_ready = !busy;
    assign wr        = cfg_valid && cfg_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            actv_len <= 16'd1;
            wgt_len  <= 16'd1;
            psum_len <= 16'd1;
            total    <= '0;     // nothing to run until configured
        end else if (wr) begin
            case (cfg_kind)
                ACTV_LEN: actv_len <= cfg_data.count;
                WGT_LEN:  wgt_len  <= cfg_data.count;
                PSUM_LEN: psum_len <= cfg_data.count;
                TOTAL:    total    <= cfg_data.count;
                default:  ;
            endcase
        end
    end

    // one entry holds the address of all three streams for one index
    always_ff @(posedge clk) begin
        if (wr && cfg_kind == ENTRY) begin
            actv_tab[cfg_index] <= cfg_data.entry.actv;
            wgt_tab[cfg_index]  <= cfg_data.entry.wgt;
            psum_tab[cfg_index] <= cfg_data.entry.psum;
        end
    end

    assign actv_addr = actv_tab[actv_idx];
    assign wgt_addr  = wgt_tab[wgt_idx];
    assign psum_addr = psum_tab[psum_idx];

endmodule

//--- tile_sequencer.sv
/*
 * tile sequencer, first pipeline stage
 * steps the activation, weight and psum tile indices with their ping-pong
 * bank bits and stalls until the banks a step needs are ready
 */
`timescale 1ns/10ps

module tile_sequencer #(
    parameter int TM_DEPTH = 16
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  pe_ctrl_pkg::step_t actv_len,
    input  pe_ctrl_pkg::step_t wgt_len,
    input  pe_ctrl_pkg::step_t psum_len,
    input  pe_ctrl_pkg::step_t total,
    input  logic [1:0]         actv_avail,
    input  logic [1:0]         wgt_avail,
    input  logic [1:0]         psum_avail,
    output logic               busy,
    tm_index_if.source         step
);
    import pe_ctrl_pkg::*;

    localparam int IDX_W = $clog2(TM_DEPTH);

    // streams are indexed 0 actv, 1 wgt, 2 psum
    logic [IDX_W-1:0] idx [3];
    logic [1:0]       spent [3];    // bank already used up, waiting for tracker to see it
    logic [1:0]       avail [3];
    step_t            len [3];
    logic [2:0]       bank;
    logic [2:0]       last;
    step_t            step_cnt;
    logic             final_step;
    logic             ok;
    logic             fire;

    assign len   = '{actv_len, wgt_len, psum_len};
    assign avail = '{actv_avail, wgt_avail, psum_avail};

    assign final_step = step_cnt == total - 16'd1;

    always_comb begin
        ok = busy;
        for (int i = 0; i < 3; i++) begin
            last[i] = step_t'(idx[i]) == len[i] - 16'd1;
            ok      = ok & avail[i][bank[i]] & ~spent[i][bank[i]];
        end
        last[2] = last[2] | final_step;     // a cut psum tile still gets flushed
    end

    assign step.valid     = ok;
    assign step.actv_idx  = idx[0];
    assign step.wgt_idx   = idx[1];
    assign step.psum_idx  = idx[2];
    assign step.actv_bank = bank[0];
    assign step.wgt_bank  = bank[1];
    assign step.psum_bank = bank[2];
    assign step.actv_last = last[0];
    assign step.wgt_last  = last[1];
    assign step.psum_last = last[2];

    assign fire = step.valid && step.ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            bank     <= '0;
            for (int i = 0; i < 3; i++) begin
                idx[i]   <= '0;
                spent[i] <= '0;
            end
        end else if (start && !busy) begin
            busy     <= total != '0;
            step_cnt <= '0;
            bank     <= '0;
            for (int i = 0; i < 3; i++) begin
                idx[i]   <= '0;
                spent[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                for (int b = 0; b < 2; b++) begin
                    if (!avail[i][b])
                        spent[i][b] <= 1'b0;    // tracker has taken the bank back
                end
                if (fire && last[i]) begin
                    idx[i]            <= '0;
                    bank[i]           <= ~bank[i];  // swap ping-pong bank
                    spent[i][bank[i]] <= 1'b1;
                end else if (fire) begin
                    idx[i] <= idx[i] + 1'b1;
                end
            end
            if (fire) begin
                step_cnt <= step_cnt + 16'd1;
                if (final_step)
                    busy <= 1'b0;
            end
        end
    end

endmodule

//--- addr_lookup.sv
/*
 * address lookup, second pipeline stage
 * reads the rf addresses of a step from the table and registers them
 * with the bank bits and the last-of-tile flags
 */
`timescale 1ns/10ps

module addr_lookup (
    input  logic                              clk,
    input  logic                              reset,
    tm_index_if.sink                          step,
    output logic [$bits(step.actv_idx)-1:0]   actv_idx,
    output logic [$bits(step.wgt_idx)-1:0]    wgt_idx,
    output logic [$bits(step.psum_idx)-1:0]   psum_idx,
    input  logic [pe_ctrl_pkg::ACTV_AW-1:0]   actv_addr,
    input  logic [pe_ctrl_pkg::WGT_AW-1:0]    wgt_addr,
    input  logic [pe_ctrl_pkg::PSUM_AW-1:0]   psum_addr,
    rf_addr_if.source                         rf
);
    assign actv_idx = step.actv_idx;
    assign wgt_idx  = step.wgt_idx;
    assign psum_idx = step.psum_idx;

    assign step.ready = !rf.valid || rf.ready;  // empty or item leaving

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            rf.valid <= 1'b0;
        else if (step.ready)
            rf.valid <= step.valid;
    end

    always_ff @(posedge clk) begin
        if (step.valid && step.ready) begin
            rf.actv_addr <= actv_addr;
            rf.wgt_addr  <= wgt_addr;
            rf.psum_addr <= psum_addr;
            rf.actv_bank <= step.actv_bank;
            rf.wgt_bank  <= step.wgt_bank;
            rf.psum_bank <= step.psum_bank;
            rf.actv_last <= step.actv_last;
            rf.wgt_last  <= step.wgt_last;
            rf.psum_last <= step.psum_last;
        end
    end

endmodule

//--- issue_stage.sv
/*
 * issue stage, output register of the controller
 * drives the address triple and bank selects to the PE array and reports
 * every accepted triple as a retire event
 */
`timescale 1ns/10ps

module issue_stage (
    input  logic                              clk,
    input  logic                              reset,
    rf_addr_if.sink                           rf,
    output logic                              addr_valid,
    input  logic                              addr_ready,
    output logic                              actv_sel,
    output logic [pe_ctrl_pkg::ACTV_AW-1:0]   actv_addr,
    output logic                              wgt_sel,
    output logic [pe_ctrl_pkg::WGT_AW-1:0]    wgt_addr,
    output logic                              psum_sel,
    output logic [pe_ctrl_pkg::PSUM_AW-1:0]   psum_addr,
    output logic                              retire,
    output logic                              retire_actv_last,
    output logic                              retire_wgt_last,
    output logic                              retire_psum_last,
    output logic                              retire_actv_bank,
    output logic                              retire_wgt_bank,
    output logic                              retire_psum_bank
);
    logic actv_last;
    logic wgt_last;
    logic psum_last;

    assign rf.ready = !addr_valid || addr_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            addr_valid <= 1'b0;
        else if (rf.ready)
            addr_valid <= rf.valid;
    end

    // sel 0 picks rf bank1, 1 picks bank2
    always_ff @(posedge clk) begin
        if (rf.valid && rf.ready) begin
            actv_sel  <= rf.actv_bank;
            wgt_sel   <= rf.wgt_bank;
            psum_sel  <= rf.psum_bank;
            actv_addr <= rf.actv_addr;
            wgt_addr  <= rf.wgt_addr;
            psum_addr <= rf.psum_addr;
            actv_last <= rf.actv_last;
            wgt_last  <= rf.wgt_last;
            psum_last <= rf.psum_last;
        end
    end

    assign retire           = addr_valid && addr_ready;
    assign retire_actv_last = actv_last;
    assign retire_wgt_last  = wgt_last;
    assign retire_psum_last = psum_last;
    assign retire_actv_bank = actv_sel;
    assign retire_wgt_bank  = wgt_sel;
    assign retire_psum_bank = psum_sel;

endmodule

//--- bank_tracker.sv
/*
 * ping-pong bank tracker
 * requests activation and weight fills from the global buffers, queues
 * psum flushes in tile order and raises conv_finish at the end of a job
 */
`timescale 1ns/10ps

module bank_tracker (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       retire,
    input  logic       retire_actv_last,
    input  logic       retire_wgt_last,
    input  logic       retire_psum_last,
    input  logic       retire_actv_bank,
    input  logic       retire_wgt_bank,
    input  logic       retire_psum_bank,
    input  logic       seq_busy,
    input  logic       lookup_valid,    // step held in the lookup stage
    input  logic       issue_valid,     // step held in the issue stage
    output logic       actv_fill_req1,
    output logic       actv_fill_req2,
    output logic       wgt_fill_req1,
    output logic       wgt_fill_req2,
    input  logic       actv_fill_done1,
    input  logic       actv_fill_done2,
    input  logic       wgt_fill_done1,
    input  logic       wgt_fill_done2,
    output logic       psum_flush_valid,
    output logic       psum_flush_bank,
    input  logic       psum_flush_ready,
    output logic [1:0] actv_avail,
    output logic [1:0] wgt_avail,
    output logic [1:0] psum_avail,
    output logic       conv_finish
);
    // fill streams are indexed 0 actv, 1 wgt
    logic [1:0] fill_pend [2];
    logic [1:0] filled [2];
    logic [1:0] done [2];
    logic [1:0] rlast;
    logic [1:0] rbank;
    logic [1:0] psum_pend;
    logic       head;       // psum tiles alternate banks, so do their flushes
    logic       running;

    assign done  = '{{actv_fill_done2, actv_fill_done1}, {wgt_fill_done2, wgt_fill_done1}};
    assign rlast = {retire_wgt_last, retire_actv_last};
    assign rbank = {retire_wgt_bank, retire_actv_bank};

    assign actv_fill_req1 = fill_pend[0][0];
    assign actv_fill_req2 = fill_pend[0][1];
    assign wgt_fill_req1  = fill_pend[1][0];
    assign wgt_fill_req2  = fill_pend[1][1];
    assign actv_avail     = filled[0];
    assign wgt_avail      = filled[1];

    assign psum_flush_valid = psum_pend[head];
    assign psum_flush_bank  = head;
    assign psum_avail       = ~psum_pend;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill_pend   <= '{2'b00, 2'b00};
            filled      <= '{2'b00, 2'b00};
            psum_pend   <= 2'b00;
            head        <= 1'b0;
            running     <= 1'b0;
            conv_finish <= 1'b0;
        end else if (start && !seq_busy) begin
            fill_pend   <= '{2'b11, 2'b11};     // load both banks up front
            filled      <= '{2'b00, 2'b00};
            psum_pend   <= 2'b00;
            head        <= 1'b0;
            running     <= 1'b1;
            conv_finish <= 1'b0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                for (int b = 0; b < 2; b++) begin
                    if (done[s][b] && fill_pend[s][b]) begin
                        fill_pend[s][b] <= 1'b0;
                        filled[s][b]    <= 1'b1;
                    end
                end
                if (retire && rlast[s]) begin   // tile done, refill its bank for tile k+2
                    filled[s][rbank[s]]    <= 1'b0;
                    fill_pend[s][rbank[s]] <= 1'b1;
                end
            end
            if (psum_flush_valid && psum_flush_ready) begin
                psum_pend[head] <= 1'b0;
                head            <= ~head;
            end
            if (retire && retire_psum_last)
                psum_pend[retire_psum_bank] <= 1'b1;
            if (running && !seq_busy && !lookup_valid && !issue_valid && psum_pend == 2'b00) begin
                running     <= 1'b0;
                conv_finish <= 1'b1;
            end
        end
    end

endmodule

//--- pe_array_ctrl.sv
/*
 * PE array controller top level
 * three stage pipeline that issues register file addresses per compute
 * step, with fill and flush handshakes towards the global buffers
 */
`timescale 1ns/10ps

module pe_array_ctrl #(
    parameter int TM_DEPTH = 16
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cfg_valid,
    output logic                              cfg_ready,
    input  pe_ctrl_pkg::cfg_kind_t            cfg_kind,
    input  logic [$clog2(TM_DEPTH)-1:0]       cfg_index,
    input  pe_ctrl_pkg::cfg_word_t            cfg_data,
    input  logic                              start,
    output logic                              conv_finish,
    output logic                              addr_valid,
    input  logic                              addr_ready,
    output logic                              actv_sel,
    output logic [pe_ctrl_pkg::ACTV_AW-1:0]   actv_addr,
    output logic                              wgt_sel,
    output logic [pe_ctrl_pkg::WGT_AW-1:0]    wgt_addr,
    output logic                              psum_sel,
    output logic [pe_ctrl_pkg::PSUM_AW-1:0]   psum_addr,
    output logic                              actv_fill_req1,
    output logic                              actv_fill_req2,
    output logic                              wgt_fill_req1,
    output logic                              wgt_fill_req2,
    input  logic                              actv_fill_done1,
    input  logic                              actv_fill_done2,
    input  logic                              wgt_fill_done1,
    input  logic                              wgt_fill_done2,
    output logic                              psum_flush_valid,
    output logic                              psum_flush_bank,
    input  logic                              psum_flush_ready
);
    import pe_ctrl_pkg::*;

    localparam int IDX_W = $clog2(TM_DEPTH);

    step_t              actv_len, wgt_len, psum_len, total;
    logic [IDX_W-1:0]   lk_actv_idx, lk_wgt_idx, lk_psum_idx;
    logic [ACTV_AW-1:0] lk_actv_addr;
    logic [WGT_AW-1:0]  lk_wgt_addr;
    logic [PSUM_AW-1:0] lk_psum_addr;
    logic [1:0]         actv_avail, wgt_avail, psum_avail;
    logic               seq_busy;
    logic               retire, ret_actv_last, ret_wgt_last, ret_psum_last;
    logic               ret_actv_bank, ret_wgt_bank, ret_psum_bank;

    tm_index_if #(.IDX_W(IDX_W)) step_link ();
    rf_addr_if rf_link ();

    tm_config_store #(.TM_DEPTH(TM_DEPTH)) i_config (
        .clk, .reset, .cfg_valid, .cfg_kind, .cfg_index, .cfg_data, .cfg_ready,
        .busy(seq_busy), .actv_len, .wgt_len, .psum_len, .total,
        .actv_idx(lk_actv_idx), .wgt_idx(lk_wgt_idx), .psum_idx(lk_psum_idx),
        .actv_addr(lk_actv_addr), .wgt_addr(lk_wgt_addr), .psum_addr(lk_psum_addr)
    );

    tile_sequencer #(.TM_DEPTH(TM_DEPTH)) i_sequencer (
        .clk, .reset, .start, .actv_len, .wgt_len, .psum_len, .total,
        .actv_avail, .wgt_avail, .psum_avail, .busy(seq_busy), .step(step_link)
    );

    addr_lookup i_lookup (
        .clk, .reset, .step(step_link),
        .actv_idx(lk_actv_idx), .wgt_idx(lk_wgt_idx), .psum_idx(lk_psum_idx),
        .actv_addr(lk_actv_addr), .wgt_addr(lk_wgt_addr), .psum_addr(lk_psum_addr),
        .rf(rf_link)
    );

    issue_stage i_issue (
        .clk, .reset, .rf(rf_link), .addr_valid, .addr_ready,
        .actv_sel, .actv_addr, .wgt_sel, .wgt_addr, .psum_sel, .psum_addr, .retire,
        .retire_actv_last(ret_actv_last), .retire_wgt_last(ret_wgt_last),
        .retire_psum_last(ret_psum_last), .retire_actv_bank(ret_actv_bank),
        .retire_wgt_bank(ret_wgt_bank), .retire_psum_bank(ret_psum_bank)
    );

    bank_tracker i_tracker (
        .clk, .reset, .start, .retire,
        .retire_actv_last(ret_actv_last), .retire_wgt_last(ret_wgt_last),
        .retire_psum_last(ret_psum_last), .retire_actv_bank(ret_actv_bank),
        .retire_wgt_bank(ret_wgt_bank), .retire_psum_bank(ret_psum_bank),
        .seq_busy, .lookup_valid(rf_link.valid), .issue_valid(addr_valid),
        .actv_fill_req1, .actv_fill_req2, .wgt_fill_req1, .wgt_fill_req2,
        .actv_fill_done1, .actv_fill_done2, .wgt_fill_done1, .wgt_fill_done2,
        .psum_flush_valid, .psum_flush_bank, .psum_flush_ready,
        .actv_avail, .wgt_avail, .psum_avail, .conv_finish
    );

endmodule

//--- tb_pe_array_ctrl_assert.sv
/*
 * handshake checks for a valid/ready source
 * bound to the address output and to the psum flush port
 */
`timescale 1ns/10ps

module tb_pe_array_ctrl_assert #(
    parameter int W = 1
) (
    input logic         clk,
    input logic         reset,
    input logic         valid,
    input logic         ready,
    input logic [W-1:0] payload
);
    property hold_valid;
        @(posedge clk) disable iff (reset) valid && !ready |=> valid;
    endproperty

    property hold_payload;
        @(posedge clk) disable iff (reset) valid && !ready |=> $stable(payload);
    endproperty

    a_hold_valid: assert property (hold_valid)
        else $error("valid dropped while stalled");
    a_hold_payload: assert property (hold_payload)
        else $error("payload changed while stalled");
    a_valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(valid))
        else $error("valid is unknown");
endmodule

bind issue_stage tb_pe_array_ctrl_assert #(.W(9)) i_issue_chk (
    .clk, .reset, .valid(addr_valid), .ready(addr_ready),
    .payload({actv_sel, actv_addr, wgt_sel, wgt_addr, psum_sel, psum_addr})
);

bind bank_tracker tb_pe_array_ctrl_assert #(.W(1)) i_flush_chk (
    .clk, .reset, .valid(psum_flush_valid), .ready(psum_flush_ready),
    .payload(psum_flush_bank)
);

//--- tb_pe_array_ctrl.sv
/*
 * testbench for the PE array controller
 * runs jobs from the vector file, plays the global buffers and the psum
 * adder, and checks every accepted step against a reference model
 */
`timescale 1ns/10ps

module tb_pe_array_ctrl;
    import pe_ctrl_pkg::*;

    localparam int TM_DEPTH = 16;
    localparam int JOB_W    = 24;

    logic clk, reset, cfg_valid, cfg_ready, start, conv_finish;
    cfg_kind_t cfg_kind;
    logic [3:0] cfg_index;
    cfg_word_t cfg_data;
    logic addr_valid, addr_ready, actv_sel, wgt_sel, psum_sel;
    logic [ACTV_AW-1:0] actv_addr;
    logic [WGT_AW-1:0] wgt_addr;
    logic [PSUM_AW-1:0] psum_addr;
    logic [3:0] fill_req;   // actv1, actv2, wgt1, wgt2
    logic [3:0] fill_done;
    logic psum_flush_valid, psum_flush_bank, psum_flush_ready;

    logic [15:0] vec [128];
    integer seed = 32'h179fe46a;
    step_t la, lw, lp, tot, exp_flush;
    int fill_dly, flush_dly, limit_cycles;
    bit stall_on, job_on, loaded, prev_stall, fl_act;
    cfg_word_t tab [TM_DEPTH];
    step_t acc, nflush;
    int fills_done [4];
    int req_cnt [4];
    int f_cnt [4];
    int fl_cnt;
    bit [3:0] f_act;
    logic [3:0] req_prev;
    logic [8:0] held;

    pe_array_ctrl #(.TM_DEPTH(TM_DEPTH)) i_pe_array_ctrl (
        .clk, .reset, .cfg_valid, .cfg_ready, .cfg_kind, .cfg_index, .cfg_data,
        .start, .conv_finish, .addr_valid, .addr_ready,
        .actv_sel, .actv_addr, .wgt_sel, .wgt_addr, .psum_sel, .psum_addr,
        .actv_fill_req1(fill_req[0]), .actv_fill_req2(fill_req[1]),
        .wgt_fill_req1(fill_req[2]), .wgt_fill_req2(fill_req[3]),
        .actv_fill_done1(fill_done[0]), .actv_fill_done2(fill_done[1]),
        .wgt_fill_done1(fill_done[2]), .wgt_fill_done2(fill_done[3]),
        .psum_flush_valid, .psum_flush_bank, .psum_flush_ready
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_addr(input string name, input logic [ACTV_AW-1:0] got,
                              input logic [ACTV_AW-1:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0b exp=%0b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input step_t got, input step_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    // reference model for accepted step number acc
    task automatic check_step();
        step_t ka, kw, kp;
        cfg_word_t ea, ew, ep;
        ka = acc / la;
        kw = acc / lw;
        kp = acc / lp;
        ea = tab[acc % la];
        ew = tab[acc % lw];
        ep = tab[acc % lp];
        check_addr("actv_addr", actv_addr, ea.entry.actv);
        check_addr("wgt_addr", wgt_addr, ew.entry.wgt);
        check_addr("psum_addr", psum_addr, ep.entry.psum);
        check_flag("actv_sel", actv_sel, ka[0]);
        check_flag("wgt_sel", wgt_sel, kw[0]);
        check_flag("psum_sel", psum_sel, kp[0]);
        if (fills_done[ka[0]] < ka / 2 + 1 || fills_done[2 + kw[0]] < kw / 2 + 1) begin
            $display("step %0d was accepted before its bank fill completed", acc);
            stop_run();
        end
        if (kp >= 2 && nflush < kp - 1) begin
            $display("step %0d was accepted before the psum flush of tile %0d", acc, kp - 2);
            stop_run();
        end
    endtask

    task automatic cfg_write(input cfg_kind_t kind, input int index, input cfg_word_t data);
        @(negedge clk);
        cfg_valid = 1'b1;
        cfg_kind  = kind;
        cfg_index = index[3:0];
        cfg_data  = data;
        @(posedge clk);
        check_flag("cfg_ready", cfg_ready, 1'b1);
    endtask

    task automatic run_job(input int j);
        int base;
        int f;
        base      = 1 + j * JOB_W;
        la        = vec[base];
        lw        = vec[base + 1];
        lp        = vec[base + 2];
        tot       = vec[base + 3];
        fill_dly  = vec[base + 4];
        flush_dly = vec[base + 5];
        stall_on  = vec[base + 6] != 0;
        exp_flush = vec[base + 7];
        for (int i = 0; i < TM_DEPTH; i++)
            tab[i] = vec[base + 8 + i];
        cfg_write(ACTV_LEN, 0, la);
        cfg_write(WGT_LEN, 0, lw);
        cfg_write(PSUM_LEN, 0, lp);
        cfg_write(TOTAL, 0, tot);
        for (int i = 0; i < TM_DEPTH; i++)
            cfg_write(ENTRY, i, tab[i]);
        @(negedge clk);
        cfg_valid = 1'b0;
        acc = '0;
        nflush = '0;
        prev_stall = 1'b0;
        req_prev = '0;
        for (int c = 0; c < 4; c++) begin
            fills_done[c] = 0;
            req_cnt[c] = 0;
        end
        job_on = 1'b1;
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        do @(posedge clk); while (!conv_finish);
        @(negedge clk);
        check_count("accepted steps", acc, tot);
        check_count("psum flushes", nflush, exp_flush);
        check_flag("cfg_ready after finish", cfg_ready, 1'b1);
        while (fill_req != '0 || f_act != '0)
            @(negedge clk);
        // two up front, then one per full tile on the bank it used
        for (int c = 0; c < 4; c++) begin
            f = (c < 2) ? tot / la : tot / lw;
            check_count($sformatf("fill requests ch%0d", c), step_t'(req_cnt[c]),
                        step_t'(1 + f / 2 + ((c % 2 == 0) ? f % 2 : 0)));
        end
        job_on = 1'b0;
    endtask

    // global buffer, psum adder and PE array side on the falling edge
    always @(negedge clk) begin
        for (int c = 0; c < 4; c++) begin
            fill_done[c] = 1'b0;
            if (f_act[c]) begin
                if (f_cnt[c] == 0) begin
                    fill_done[c] = 1'b1;
                    f_act[c] = 1'b0;
                    fills_done[c]++;
                end else
                    f_cnt[c]--;
            end else if (fill_req[c]) begin
                f_act[c] = 1'b1;
                f_cnt[c] = fill_dly + ($random(seed) & 3);
            end
        end
        psum_flush_ready = 1'b0;
        if (fl_act) begin
            if (fl_cnt == 0) begin
                psum_flush_ready = 1'b1;
                fl_act = 1'b0;
            end else
                fl_cnt--;
        end else if (psum_flush_valid) begin
            fl_act = 1'b1;
            fl_cnt = flush_dly + ($random(seed) & 3);
        end
        addr_ready = stall_on ? (($random(seed) & 3) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        if (job_on) begin
            for (int c = 0; c < 4; c++)
                if (fill_req[c] && !req_prev[c])
                    req_cnt[c]++;
            req_prev = fill_req;
            if (prev_stall) begin
                check_flag("addr_valid under stall", addr_valid, 1'b1);
                check_flag("actv_sel under stall", actv_sel, held[8]);
                check_addr("actv_addr under stall", actv_addr, held[7:6]);
                check_flag("wgt_sel under stall", wgt_sel, held[5]);
                check_addr("wgt_addr under stall", wgt_addr, held[4:3]);
                check_flag("psum_sel under stall", psum_sel, held[2]);
                check_addr("psum_addr under stall", psum_addr, held[1:0]);
            end
            prev_stall = addr_valid && !addr_ready;
            held = {actv_sel, actv_addr, wgt_sel, wgt_addr, psum_sel, psum_addr};
            if (addr_valid && addr_ready) begin
                check_step();
                acc++;
            end
            if (psum_flush_valid && psum_flush_ready) begin
                check_flag("psum_flush_bank", psum_flush_bank, nflush[0]);
                nflush++;
            end
        end
    end

    initial begin
        int njobs;
        int steps;
        reset = 1'b1;
        cfg_valid = 1'b0;
        cfg_kind = ACTV_LEN;
        cfg_index = '0;
        cfg_data = '0;
        start = 1'b0;
        addr_ready = 1'b0;
        fill_done = '0;
        psum_flush_ready = 1'b0;
        f_act = '0;
        fl_act = 1'b0;
        $readmemh("pe_ctrl_vectors.txt", vec);
        njobs = vec[0];
        steps = 0;
        for (int j = 0; j < njobs; j++)
            steps += vec[1 + j * JOB_W + 3];
        limit_cycles = steps * 60 + 2000;   // worst case fill and stall per step
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag("addr_valid after reset", addr_valid, 1'b0);
        check_flag("conv_finish after reset", conv_finish, 1'b0);
        check_flag("psum_flush_valid after reset", psum_flush_valid, 1'b0);
        check_flag("fill requests after reset", |fill_req, 1'b0);
        check_flag("cfg_ready after reset", cfg_ready, 1'b1);
        for (int j = 0; j < njobs; j++)
            run_job(j);
        $display("TEST RESULT: PASS");
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout, the jobs did not finish within %0d cycles", limit_cycles);
        stop_run();
    end

endmodule

//--- pe_ctrl_vectors.txt
// word 0 job count, then 24 words per job, all hex
// actv_len wgt_len psum_len total fill_dly flush_dly stall exp_flushes, then 16 table entries
0003
// job 1, no back-pressure, quick responders
0004 0003 0005 000c 0000 0000 0000 0003
0039 0006 0012 002d
0021 003f 0008 0014
0033 0001 002a 001c
0017 0030 000b 0025
// job 2, same mapping under random addr_ready and slow responders
0004 0003 0005 000c 0006 0008 0001 0003
0039 0006 0012 002d
0021 003f 0008 0014
0033 0001 002a 001c
0017 0030 000b 0025
// job 3, new lengths after reconfiguration
0002 0006 0004 0010 0003 0005 0001 0004
000e 0031 0024 001b
003a 0005 0016 0029
0002 003d 0010 000f
0027 0018 0033 002c

//--- list.f
pe_ctrl_pkg.sv
pe_ctrl_if.sv
tm_config_store.sv
tile_sequencer.sv
addr_lookup.sv
issue_stage.sv
bank_tracker.sv
pe_array_ctrl.sv
tb_pe_array_ctrl_assert.sv
tb_pe_array_ctrl.sv
